// File: hdl/noc_arb_pkg.sv
// Shared definitions for the five-port NoC switch allocator: port and flit encodings, request and grant records.
`default_nettype none

package noc_arb_pkg;

	localparam int NUM_PORTS   = 5;             // N, S, W, E and local.
	localparam int COORD_W     = 4;             // Width of one mesh coordinate.
	localparam int FLIT_DATA_W = 16;            // Payload width of one flit.

	// Where YX routing finds the coordinates.
	localparam int POS_W      = 2 * COORD_W;    // Router position, y above x.
	localparam int DEST_X_LSB = 0;              // Destination x in a head flit.
	localparam int DEST_Y_LSB = COORD_W;        // Destination y sits right above x.

	// Port index doubles as the route direction.
	typedef enum logic [2:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} port_dir_e;

	typedef enum logic [1:0] {
		FLIT_HEAD = 2'd0,
		FLIT_BODY = 2'd1,
		FLIT_TAIL = 2'd2
	} flit_kind_e;

	typedef struct packed {
		flit_kind_e             kind;
		logic [FLIT_DATA_W-1:0] data;           // Head flit carries {y, x} in the low byte.
	} flit_t;

	// Route request from one input, seen by every output.
	typedef struct packed {
		logic      valid;                       // A next hop is latched.
		port_dir_e dir;                         // Output this packet wants.
		logic      last;                        // Next read pops the final flit.
	} route_req_t;

	// Ownership of one output.
	typedef struct packed {
		logic      active;                      // Output is held by a packet.
		port_dir_e src;                         // Input that owns it.
	} grant_t;

endpackage

`default_nettype wire

// File: hdl/input_route_unit.sv
// Input route unit: YX route decode of the head flit, next-hop register and packet flit tracker.
`default_nettype none

module input_route_unit #(
	parameter int PKT_FLITS = 4
) (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic [noc_arb_pkg::POS_W-1:0]   yx_pos_i,
	input  noc_arb_pkg::flit_t              ib_flit_i,
	input  logic                            ib_empty_i,
	input  logic                            ib_read_i,
	output noc_arb_pkg::route_req_t         req_o
);

	import noc_arb_pkg::*;

	localparam int CNT_W = (PKT_FLITS > 2) ? $clog2(PKT_FLITS) : 1;

	logic [COORD_W-1:0] dest_x;
	logic [COORD_W-1:0] dest_y;
	logic [COORD_W-1:0] pos_x;
	logic [COORD_W-1:0] pos_y;
	port_dir_e          route_dir;
	port_dir_e          next_hop_q;
	logic               in_flight_q;
	logic [CNT_W-1:0]   flit_cnt_q;
	logic               load_hop;
	logic               last_flit;

	assign dest_x = ib_flit_i.data[DEST_X_LSB +: COORD_W];
	assign dest_y = ib_flit_i.data[DEST_Y_LSB +: COORD_W];
	assign pos_x  = yx_pos_i[DEST_X_LSB +: COORD_W];
	assign pos_y  = yx_pos_i[DEST_Y_LSB +: COORD_W];

	// Dimension order routing: settle y first, then x.
	always_comb begin
		if (dest_y > pos_y) begin
			route_dir = PORT_N;
		end else if (dest_y < pos_y) begin
			route_dir = PORT_S;
		end else if (dest_x > pos_x) begin
			route_dir = PORT_E;
		end else if (dest_x < pos_x) begin
			route_dir = PORT_W;
		end else begin
			route_dir = PORT_L;                     // Packet has arrived.
		end
	end

	// Only a head flit at the front of an idle input opens a packet.
	assign load_hop  = !ib_empty_i && !in_flight_q && (ib_flit_i.kind == FLIT_HEAD);
	assign last_flit = in_flight_q && (flit_cnt_q == CNT_W'(PKT_FLITS - 1));

	always_ff @(posedge clk) begin
		if (load_hop) begin
			next_hop_q <= route_dir;                // Held for the whole packet.
		end
	end

	// Packet tracker counts reads until the tail leaves.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			in_flight_q <= 1'b0;
			flit_cnt_q  <= '0;
		end else if (load_hop) begin
			in_flight_q <= 1'b1;
			flit_cnt_q  <= '0;
		end else if (in_flight_q && ib_read_i) begin
			if (last_flit) begin
				in_flight_q <= 1'b0;                // Tail read, back to idle.
				flit_cnt_q  <= '0;
			end else begin
				flit_cnt_q <= flit_cnt_q + 1'b1;
			end
		end
	end

	assign req_o.valid = in_flight_q;
	assign req_o.dir   = next_hop_q;
	assign req_o.last  = last_flit;

endmodule

`default_nettype wire

// File: hdl/output_rr_allocator.sv
// Output allocator: round-robin grant held for a whole packet, gated by a downstream credit counter.
`default_nettype none

module output_rr_allocator #(
	parameter int BUF_DEPTH = 4,
	parameter int OUT_PORT  = 0
) (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  noc_arb_pkg::route_req_t             req_i [noc_arb_pkg::NUM_PORTS],
	input  logic [noc_arb_pkg::NUM_PORTS-1:0]   ib_empty_i,
	input  logic                                credit_i,
	output noc_arb_pkg::grant_t                 grant_o,
	output logic                                go_o
);

	import noc_arb_pkg::*;

	localparam int CRED_W = $clog2(BUF_DEPTH + 1);

	typedef enum logic {
		ALLOC_IDLE,
		ALLOC_BUSY
	} alloc_state_e;

	alloc_state_e           state_q;
	port_dir_e              ptr_q;
	port_dir_e              src_q;
	port_dir_e              winner;
	logic [CRED_W-1:0]      credit_q;
	logic [NUM_PORTS-1:0]   req_vec;
	logic                   req_any;
	logic                   pkt_done;

	// Step one place around the ring N, S, W, E, L.
	function automatic port_dir_e ring_next(input port_dir_e p);
		port_dir_e n;
		if (p == PORT_L) begin
			n = PORT_N;
		end else begin
			n = port_dir_e'(p + 3'd1);
		end
		return n;
	endfunction

	// Inputs asking for this output. A port never routes back to itself.
	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			req_vec[i] = req_i[i].valid
				&& (req_i[i].dir == port_dir_e'(OUT_PORT))
				&& (i != OUT_PORT);
		end
	end

	// First requester at or after the pointer wins.
	always_comb begin
		int idx;
		req_any = 1'b0;
		winner  = PORT_N;
		for (int k = 0; k < NUM_PORTS; k++) begin
			idx = int'(ptr_q) + k;
			if (idx >= NUM_PORTS) begin
				idx = idx - NUM_PORTS;
			end
			if (!req_any && req_vec[idx]) begin
				req_any = 1'b1;
				winner  = port_dir_e'(idx);
			end
		end
	end

	// A flit moves only with an owner, data in its buffer and a free slot downstream.
	assign go_o     = (state_q == ALLOC_BUSY) && !ib_empty_i[src_q] && (credit_q != '0);
	assign pkt_done = go_o && req_i[src_q].last;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= ALLOC_IDLE;
			ptr_q   <= PORT_N;
			src_q   <= PORT_N;
		end else begin
			case (state_q)
				ALLOC_IDLE: begin
					if (req_any) begin
						state_q <= ALLOC_BUSY;
						src_q   <= winner;
					end
				end
				ALLOC_BUSY: begin
					if (pkt_done) begin
						state_q <= ALLOC_IDLE;
						ptr_q   <= ring_next(src_q);    // Winner drops to lowest priority.
					end
				end
				default: state_q <= ALLOC_IDLE;
			endcase
		end
	end

	// One slot used per flit sent, one returned per credit pulse.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			credit_q <= CRED_W'(BUF_DEPTH);
		end else begin
			case ({go_o, credit_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;      // Both or neither leave the count alone.
			endcase
		end
	end

	assign grant_o.active = (state_q == ALLOC_BUSY);
	assign grant_o.src    = src_q;

endmodule

`default_nettype wire

// File: hdl/switch_crossbar.sv
// Switch crossbar: input buffer read strobes and registered output flit selection.
`default_nettype none

module switch_crossbar (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  noc_arb_pkg::flit_t                  ib_flit_i [noc_arb_pkg::NUM_PORTS],
	input  noc_arb_pkg::grant_t                 grant_i [noc_arb_pkg::NUM_PORTS],
	input  logic [noc_arb_pkg::NUM_PORTS-1:0]   go_i,
	output logic [noc_arb_pkg::NUM_PORTS-1:0]   ib_read_o,
	output noc_arb_pkg::flit_t                  out_flit_o [noc_arb_pkg::NUM_PORTS],
	output logic [noc_arb_pkg::NUM_PORTS-1:0]   out_valid_o
);

	import noc_arb_pkg::*;

	// An input is popped when any output it owns moves a flit.
	always_comb begin
		ib_read_o = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			for (int o = 0; o < NUM_PORTS; o++) begin
				if (grant_i[o].active && (grant_i[o].src == port_dir_e'(i)) && go_i[o]) begin
					ib_read_o[i] = 1'b1;
				end
			end
		end
	end

	// Flit data only changes when a flit is sent.
	always_ff @(posedge clk) begin
		for (int o = 0; o < NUM_PORTS; o++) begin
			if (go_i[o]) begin
				out_flit_o[o] <= ib_flit_i[grant_i[o].src];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			out_valid_o <= '0;
		end else begin
			out_valid_o <= go_i;                // One cycle after the read.
		end
	end

endmodule

`default_nettype wire

// File: hdl/noc_switch_allocator_top.sv
// Five-port mesh router switch allocator: route decode, per-output arbitration and crossbar.
`default_nettype none

module noc_switch_allocator_top #(
	parameter int PKT_FLITS = 4,
	parameter int BUF_DEPTH = 4
) (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic [noc_arb_pkg::POS_W-1:0]       yx_pos_i,
	input  noc_arb_pkg::flit_t                  ib_flit_i [noc_arb_pkg::NUM_PORTS],
	input  logic [noc_arb_pkg::NUM_PORTS-1:0]   ib_empty_i,
	output logic [noc_arb_pkg::NUM_PORTS-1:0]   ib_read_o,
	input  logic [noc_arb_pkg::NUM_PORTS-1:0]   credit_i,
	output noc_arb_pkg::flit_t                  out_flit_o [noc_arb_pkg::NUM_PORTS],
	output logic [noc_arb_pkg::NUM_PORTS-1:0]   out_valid_o
);

	import noc_arb_pkg::*;

	route_req_t             route_req [NUM_PORTS];  // Indexed by input.
	grant_t                 grant [NUM_PORTS];      // Indexed by output.
	logic [NUM_PORTS-1:0]   go;                     // Indexed by output.

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

		input_route_unit #(
			.PKT_FLITS (PKT_FLITS)
		) input_route_unit_inst (
			.clk        (clk),
			.rst_n_i    (rst_n_i),
			.yx_pos_i   (yx_pos_i),
			.ib_flit_i  (ib_flit_i[p]),
			.ib_empty_i (ib_empty_i[p]),
			.ib_read_i  (ib_read_o[p]),         // Each pop advances the tracker.
			.req_o      (route_req[p])
		);

		// Every allocator sees every request.
		output_rr_allocator #(
			.BUF_DEPTH (BUF_DEPTH),
			.OUT_PORT  (p)
		) output_rr_allocator_inst (
			.clk        (clk),
			.rst_n_i    (rst_n_i),
			.req_i      (route_req),
			.ib_empty_i (ib_empty_i),
			.credit_i   (credit_i[p]),
			.grant_o    (grant[p]),
			.go_o       (go[p])
		);

	end

	switch_crossbar switch_crossbar_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ib_flit_i   (ib_flit_i),
		.grant_i     (grant),
		.go_i        (go),
		.ib_read_o   (ib_read_o),
		.out_flit_o  (out_flit_o),
		.out_valid_o (out_valid_o)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Testbench clock and reset source: free running clock and a reset held low for a set number of cycles.
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 4,
	parameter int RST_CYCLES     = 4
) (
	output logic clk_o,
	output logic rst_n_o
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever begin
			#(HALF_PERIOD_NS) clk_o = ~clk_o;
		end
	end

	// Reset is released on a rising edge, like every other stimulus.
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/noc_arb_tb.sv
// Testbench for the NoC switch allocator: input buffer models, YX scoreboards, credit model and checks.
`default_nettype none

module noc_arb_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import noc_arb_pkg::*;

	localparam int PKT_FLITS    = 4;
	localparam int BUF_DEPTH    = 4;
	localparam int ROUTER_Y     = 5;
	localparam int ROUTER_X     = 5;
	localparam int QUIET_CYCLES = 12;          // Long enough for a stalled output to show a flit.
	localparam logic [POS_W-1:0] ROUTER_POS = {COORD_W'(ROUTER_Y), COORD_W'(ROUTER_X)};

	logic                 clk;
	logic                 rst_n;
	flit_t                ib_flit [NUM_PORTS] = '{default: '0};
	logic [NUM_PORTS-1:0] ib_empty = '1;
	logic [NUM_PORTS-1:0] ib_read;
	logic [NUM_PORTS-1:0] credit = '0;
	flit_t                out_flit [NUM_PORTS];
	logic [NUM_PORTS-1:0] out_valid;

	flit_t                ib_q [NUM_PORTS][$];  // Input buffer contents, front is the head.
	flit_t                exp_q [NUM_PORTS][$]; // Expected flits per output.
	logic [NUM_PORTS-1:0] credit_pipe [3] = '{default: '0};
	logic [NUM_PORTS-1:0] manual_credit = '0;
	logic [NUM_PORTS-1:0] stall_in = '0;        // Buffers that show empty although flits wait.
	logic [NUM_PORTS-1:0] read_q = '0;
	logic                 hold_credits = 1'b0;
	int                   sent_cnt [NUM_PORTS] = '{default: 0};
	int                   used_slots [NUM_PORTS] = '{default: 0};
	int                   parallel_cnt = 0;
	int                   pkts_sent = 0;
	int                   cycle_cnt = 0;
	integer               seed = 32'h08c2_eb74;
	string                test_name = "reset";

	tb_clock_gen #(
		.HALF_PERIOD_NS (4),
		.RST_CYCLES     (4)
	) tb_clock_gen_inst (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	noc_switch_allocator_top #(
		.PKT_FLITS (PKT_FLITS),
		.BUF_DEPTH (BUF_DEPTH)
	) noc_switch_allocator_top_inst (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.yx_pos_i    (ROUTER_POS),
		.ib_flit_i   (ib_flit),
		.ib_empty_i  (ib_empty),
		.ib_read_o   (ib_read),
		.credit_i    (credit),
		.out_flit_o  (out_flit),
		.out_valid_o (out_valid)
	);

	task automatic stop_run(input string reason);
		$display("*** FAILED ***");
		$fatal(1, reason);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
		stop_run("value mismatch");
	endtask

	task automatic report_failure(input string msg);
		$display("Test %s went wrong: %s", test_name, msg);
		stop_run(msg);
	endtask

	// YX reference: the row decides first, the column only when the rows match.
	function automatic int expected_port(input int dy, input int dx);
		if (dy > ROUTER_Y) begin
			return int'(PORT_N);
		end else if (dy < ROUTER_Y) begin
			return int'(PORT_S);
		end else if (dx > ROUTER_X) begin
			return int'(PORT_E);
		end else if (dx < ROUTER_X) begin
			return int'(PORT_W);
		end
		return int'(PORT_L);
	endfunction

	// Fills one input buffer with a packet and the expected output with the same flits.
	task automatic queue_packet(input int src, input int dy, input int dx);
		flit_t f;
		int    dst;
		dst = expected_port(dy, dx);
		for (int k = 0; k < PKT_FLITS; k++) begin
			f.data = 16'($random(seed));
			if (k == 0) begin
				f.kind      = FLIT_HEAD;
				f.data[7:0] = {4'(dy), 4'(dx)};     // Destination y above x.
			end else if (k == PKT_FLITS - 1) begin
				f.kind = FLIT_TAIL;
			end else begin
				f.kind = FLIT_BODY;
			end
			ib_q[src].push_back(f);
			exp_q[dst].push_back(f);
		end
		pkts_sent++;
	endtask

	function automatic bit all_drained();
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (ib_q[i].size() != 0 || exp_q[i].size() != 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	function automatic bit inputs_empty();
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (ib_q[i].size() != 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic wait_drained();
		while (!inputs_empty()) begin
			@(negedge clk);
		end
		repeat (QUIET_CYCLES) @(negedge clk);
	endtask

	task automatic wait_sent(input int o, input int n);
		while (sent_cnt[o] < n) begin
			@(negedge clk);
		end
	endtask

	task automatic return_credit(input int o);
		@(posedge clk);
		manual_credit[o] <= 1'b1;
		@(posedge clk);
		manual_credit[o] <= 1'b0;
	endtask

	// First-word-fall-through buffers: a read pops the front, the next flit shows after the edge.
	always @(posedge clk) begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (ib_read[i] && ib_q[i].size() != 0) begin
				void'(ib_q[i].pop_front());
			end
			ib_empty[i] <= (ib_q[i].size() == 0) || stall_in[i];
			if (ib_q[i].size() != 0) begin
				ib_flit[i] <= ib_q[i][0];
			end
		end
	end

	// Downstream frees a slot three cycles after each flit unless credits are held back.
	always @(posedge clk) begin
		credit_pipe[0] <= hold_credits ? '0 : out_valid;
		credit_pipe[1] <= credit_pipe[0];
		credit_pipe[2] <= credit_pipe[1];
		credit         <= credit_pipe[2] | manual_credit;
	end

	always @(posedge clk) begin : check_outputs
		flit_t exp_flit;
		if (rst_n) begin
			assert ($countones(out_valid) == $countones(read_q))
				else report_mismatch("flits out one cycle after reads",
					32'($countones(read_q)), 32'($countones(out_valid)));
			if (out_valid[PORT_S] && out_valid[PORT_E]) begin
				parallel_cnt++;
			end
			for (int o = 0; o < NUM_PORTS; o++) begin
				used_slots[o] = used_slots[o] + int'(out_valid[o]) - int'(credit[o]);
				assert (used_slots[o] <= BUF_DEPTH)
					else report_mismatch("downstream slots in use", BUF_DEPTH, used_slots[o]);
				if (out_valid[o]) begin
					sent_cnt[o]++;
					if (exp_q[o].size() == 0) begin
						report_failure($sformatf("a flit left output %0d with none expected", o));
					end else begin
						exp_flit = exp_q[o].pop_front();
						assert (out_flit[o] == exp_flit)
							else report_mismatch($sformatf("flit on output %0d", o),
								32'(exp_flit), 32'(out_flit[o]));
					end
				end
			end
		end
		read_q <= ib_read;
	end

	// Synchronous reset leaves every strobe and valid low.
	assert property (@(posedge clk) !rst_n |=> ((out_valid == '0) && (ib_read == '0)))
		else report_mismatch("strobes after reset", 0, 32'({ib_read, out_valid}));

	assert property (@(posedge clk) disable iff (!rst_n) ((ib_read & ib_empty) == '0))
		else report_failure("read strobe on an empty input buffer");

	// Budget of 40 cycles per packet plus slack for reset and quiet periods.
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > 40 * pkts_sent + 200) begin
			report_failure("timeout");
		end
	end

	initial begin : run_tests
		int base;
		int par_base;
		@(posedge rst_n);
		repeat (4) @(negedge clk);

		test_name = "yx_routing";
		@(negedge clk);
		queue_packet(PORT_N, 5, 5);             // To local, leaves the L pointer at S.
		queue_packet(PORT_S, 9, 3);
		queue_packet(PORT_W, 5, 9);
		queue_packet(PORT_E, 5, 2);
		queue_packet(PORT_L, 1, 7);
		wait_drained();

		test_name = "round_robin";
		@(negedge clk);
		for (int r = 0; r < 2; r++) begin
			queue_packet(PORT_S, 5, 5);
			queue_packet(PORT_W, 5, 5);
			queue_packet(PORT_E, 5, 5);
		end
		wait_drained();

		test_name = "parallel";
		par_base = parallel_cnt;
		@(negedge clk);
		queue_packet(PORT_W, 5, 12);
		queue_packet(PORT_N, 2, 5);
		repeat (3) @(posedge clk);
		stall_in[PORT_W] <= 1'b1;               // W runs dry after its head has left.
		repeat (4) @(posedge clk);
		stall_in[PORT_W] <= 1'b0;
		wait_drained();
		assert (parallel_cnt > par_base)
			else report_failure("outputs S and E never sent in the same cycle");

		test_name = "credit_backpressure";
		@(posedge clk);
		hold_credits <= 1'b1;
		@(negedge clk);
		base = sent_cnt[PORT_N];
		queue_packet(PORT_S, 9, 5);
		queue_packet(PORT_S, 9, 5);
		wait_sent(PORT_N, base + BUF_DEPTH);
		repeat (QUIET_CYCLES) @(negedge clk);
		assert (sent_cnt[PORT_N] == base + BUF_DEPTH)
			else report_mismatch("flits on N without credit", base + BUF_DEPTH, sent_cnt[PORT_N]);
		for (int k = 1; k <= 2 * PKT_FLITS - BUF_DEPTH; k++) begin
			return_credit(PORT_N);
			wait_sent(PORT_N, base + BUF_DEPTH + k);
			repeat (QUIET_CYCLES) @(negedge clk);
			assert (sent_cnt[PORT_N] == base + BUF_DEPTH + k)
				else report_mismatch("flits on N per credit", base + BUF_DEPTH + k,
					sent_cnt[PORT_N]);
		end
		wait_drained();

		if (all_drained()) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			report_failure("scoreboards not empty at the end of the run");
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/noc_arb_pkg.sv
hdl/input_route_unit.sv
hdl/output_rr_allocator.sv
hdl/switch_crossbar.sv
hdl/noc_switch_allocator_top.sv
verif/tb_clock_gen.sv
verif/noc_arb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench and the switch allocator with Verilator, then run the simulation.
# A $fatal in the testbench gives a non-zero exit status, which this script passes on.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module noc_arb_tb -o noc_arb_sim &&
./obj_dir/noc_arb_sim || exit 1
